// ==== logic/rename_pkg.sv ====
package rename_pkg;

    ////////////////////
    // sizes

    localparam int arch_count = 32;
    localparam int phys_count = 64;
    localparam int tag_width  = 6;
    localparam int page_count = 8;
    localparam int free_depth = phys_count - arch_count;

    // the extra pointer bit tells a full free list from an empty one.
    localparam int free_idx_width = $clog2(free_depth);
    localparam int free_ptr_width = free_idx_width + 1;

    typedef logic [$clog2(arch_count)-1:0] arch_idx_t;
    typedef logic [tag_width-1:0]          phys_tag_t;
    typedef logic [$clog2(page_count)-1:0] page_idx_t;
    typedef logic [free_idx_width-1:0]     free_idx_t;
    typedef logic [free_ptr_width-1:0]     free_ptr_t;

    ////////////////////
    // major opcodes

    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_op_imm = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_op     = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } rv_opcode_e;

    ////////////////////
    // stage interfaces

    typedef struct packed {
        rv_opcode_e opcode;
        arch_idx_t  rs1;
        arch_idx_t  rs2;
        arch_idx_t  rd;
        logic       save;       // branch asks for a checkpoint.
        page_idx_t  save_page;
    } rename_req_t;

    typedef struct packed {
        phys_tag_t src1_tag;
        logic      src1_used;
        phys_tag_t src2_tag;
        logic      src2_used;
        phys_tag_t dst_tag;
        phys_tag_t old_tag;     // released by commit later.
        logic      dst_used;
    } rename_rsp_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } commit_t;

endpackage

// ==== logic/rename_ctrl.sv ====
`timescale 1ns/1ps

module rename_ctrl import rename_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  rename_req_t req,
    input  logic        restore_valid,
    input  logic        free_empty,
    input  phys_tag_t   head_tag,
    input  phys_tag_t   src1_map,
    input  phys_tag_t   src2_map,
    input  phys_tag_t   rd_old_map,
    output logic        stall,
    output logic        alloc,
    output logic        map_we,
    output arch_idx_t   map_wr_idx,
    output phys_tag_t   map_wr_tag,
    output logic        save_en,
    output logic        rsp_valid,
    output rename_rsp_t rsp
);

    logic uses_rs1;
    logic uses_rs2;
    logic writes_rd;
    logic src1_used;
    logic src2_used;
    logic dst_used;
    logic accept;

    ////////////////////
    // opcode classes

    always_comb begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        writes_rd = 1'b1;
        case (req.opcode)
            op_jalr, op_load, op_op_imm: begin
                uses_rs2 = 1'b0;
            end
            op_lui, op_auipc, op_jal: begin
                uses_rs1 = 1'b0;
                uses_rs2 = 1'b0;
            end
            op_store, op_branch: begin
                writes_rd = 1'b0;
            end
            default: ;                                   // register-register form.
        endcase
    end

    // x0 is hardwired to tag 0 and never renamed.
    assign src1_used = uses_rs1 && (req.rs1 != '0);
    assign src2_used = uses_rs2 && (req.rs2 != '0);
    assign dst_used  = writes_rd && (req.rd != '0);

    ////////////////////
    // handshake and strobes

    assign stall  = restore_valid || (req_valid && dst_used && free_empty);
    assign accept = req_valid && !stall;

    assign alloc      = accept && dst_used;            // pops the free-list head.
    assign map_we     = alloc;
    assign map_wr_idx = req.rd;
    assign map_wr_tag = head_tag;
    assign save_en    = accept && req.save;            // after this rename and pop.

    ////////////////////
    // response register

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp.src1_tag  <= src1_used ? src1_map : '0;
            rsp.src1_used <= src1_used;
            rsp.src2_tag  <= src2_used ? src2_map : '0;
            rsp.src2_used <= src2_used;
            rsp.dst_tag   <= dst_used ? head_tag : '0;
            rsp.old_tag   <= dst_used ? rd_old_map : '0;
            rsp.dst_used  <= dst_used;
        end
    end

endmodule

// ==== logic/rat_map_table.sv ====
`timescale 1ns/1ps

module rat_map_table import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  arch_idx_t rd_idx1,
    input  arch_idx_t rd_idx2,
    input  arch_idx_t rd_idx3,
    input  logic      we,
    input  arch_idx_t wr_idx,
    input  phys_tag_t wr_tag,
    input  logic      save_en,
    input  page_idx_t save_page,
    input  logic      restore_en,
    input  page_idx_t restore_page,
    output phys_tag_t map1,
    output phys_tag_t map2,
    output phys_tag_t map3
);

    phys_tag_t [arch_count-1:0] map_q;
    phys_tag_t [arch_count-1:0] map_next;             // map with this cycle's write.
    phys_tag_t [arch_count-1:0] ckpt_q [page_count];

    ////////////////////
    // lookups

    // reads see the table before this cycle's write.
    assign map1 = map_q[rd_idx1];
    assign map2 = map_q[rd_idx2];
    assign map3 = map_q[rd_idx3];

    always_comb begin
        map_next = map_q;
        if (we) begin
            map_next[wr_idx] = wr_tag;
        end
    end

    ////////////////////
    // current mapping

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < arch_count; i++) begin
                map_q[i] <= phys_tag_t'(i);            // identity at start.
            end
        end else if (restore_en) begin
            map_q <= ckpt_q[restore_page];             // restore wins over a write.
        end else begin
            map_q <= map_next;
        end
    end

    ////////////////////
    // checkpoint pages

    // a page is only read after it was saved by a branch.
    always_ff @(posedge clk) begin
        if (save_en) begin
            ckpt_q[save_page] <= map_next;
        end
    end

endmodule

// ==== logic/free_list.sv ====
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      pop,
    input  commit_t   commit_release,
    input  logic      save_en,
    input  page_idx_t save_page,
    input  logic      restore_en,
    input  page_idx_t restore_page,
    output phys_tag_t head_tag,
    output logic      empty
);

    phys_tag_t tag_q [free_depth];
    free_ptr_t rd_ptr_q;
    free_ptr_t wr_ptr_q;
    free_ptr_t count_q;                                // 0 to free_depth.
    free_ptr_t ckpt_ptr_q [page_count];
    free_ptr_t rd_ptr_next;
    free_ptr_t wr_ptr_next;

    assign rd_ptr_next = rd_ptr_q + free_ptr_t'(pop);
    assign wr_ptr_next = wr_ptr_q + free_ptr_t'(commit_release.valid);

    assign head_tag = tag_q[free_idx_t'(rd_ptr_q)];
    assign empty    = (count_q == '0);

    ////////////////////
    // pointers and count

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= free_ptr_t'(free_depth);      // full, wrap bit set.
            count_q  <= free_ptr_t'(free_depth);
        end else begin
            wr_ptr_q <= wr_ptr_next;
            if (restore_en) begin
                rd_ptr_q <= ckpt_ptr_q[restore_page];
                count_q  <= wr_ptr_next - ckpt_ptr_q[restore_page];
            end else begin
                rd_ptr_q <= rd_ptr_next;
                count_q  <= count_q + free_ptr_t'(commit_release.valid) - free_ptr_t'(pop);
            end
        end
    end

    ////////////////////
    // tag storage

    // the free tags 32 to 63 sit in order after reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < free_depth; i++) begin
                tag_q[i] <= phys_tag_t'(arch_count + i);
            end
        end else if (commit_release.valid) begin
            tag_q[free_idx_t'(wr_ptr_q)] <= commit_release.tag;
        end
    end

    // the saved pointer already includes the branch's own pop.
    always_ff @(posedge clk) begin
        if (save_en) begin
            ckpt_ptr_q[save_page] <= rd_ptr_next;
        end
    end

endmodule

// ==== logic/rename_top.sv ====
`timescale 1ns/1ps

module rename_top import rename_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  rename_req_t req,
    input  logic        restore_valid,
    input  page_idx_t   restore_page,
    input  commit_t     commit_release,
    output logic        stall,
    output logic        rsp_valid,
    output rename_rsp_t rsp
);

    logic      free_empty;
    phys_tag_t head_tag;
    phys_tag_t src1_map;
    phys_tag_t src2_map;
    phys_tag_t rd_old_map;
    logic      alloc;
    logic      map_we;
    arch_idx_t map_wr_idx;
    phys_tag_t map_wr_tag;
    logic      save_en;

    ////////////////////
    // control

    rename_ctrl ctrl0 (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .restore_valid (restore_valid),
        .free_empty    (free_empty),
        .head_tag      (head_tag),
        .src1_map      (src1_map),
        .src2_map      (src2_map),
        .rd_old_map    (rd_old_map),
        .stall         (stall),
        .alloc         (alloc),
        .map_we        (map_we),
        .map_wr_idx    (map_wr_idx),
        .map_wr_tag    (map_wr_tag),
        .save_en       (save_en),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp)
    );

    ////////////////////
    // datapath

    // the third lookup gives the tag that rd held before this rename.
    rat_map_table rat0 (
        .clk          (clk),
        .reset        (reset),
        .rd_idx1      (req.rs1),
        .rd_idx2      (req.rs2),
        .rd_idx3      (req.rd),
        .we           (map_we),
        .wr_idx       (map_wr_idx),
        .wr_tag       (map_wr_tag),
        .save_en      (save_en),
        .save_page    (req.save_page),
        .restore_en   (restore_valid),
        .restore_page (restore_page),
        .map1         (src1_map),
        .map2         (src2_map),
        .map3         (rd_old_map)
    );

    free_list free0 (
        .clk            (clk),
        .reset          (reset),
        .pop            (alloc),
        .commit_release (commit_release),
        .save_en        (save_en),
        .save_page      (req.save_page),
        .restore_en     (restore_valid),
        .restore_page   (restore_page),
        .head_tag       (head_tag),
        .empty          (free_empty)
    );

endmodule

// ==== sim/rename_assertions.sv ====
`timescale 1ns/1ps

module rename_assertions import rename_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        req_valid,
    input rename_req_t req,
    input logic        stall,
    input logic        rsp_valid,
    input logic        free_empty,
    input logic        alloc
);

    logic needs_dst;
    int   fail_count = 0;

    assign needs_dst = (req.rd != '0) && (req.opcode != op_store) && (req.opcode != op_branch);

    rsp_follows_accept: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> $past(req_valid && !stall))
        else begin
            $error("rsp_valid without an accepted request one cycle before");
            fail_count++;
        end

    stall_when_empty: assert property (@(posedge clk) disable iff (reset)
        (req_valid && needs_dst && free_empty) |-> stall)
        else begin
            $error("destination request not stalled on an empty free list");
            fail_count++;
        end

    no_alloc_when_empty: assert property (@(posedge clk) disable iff (reset)
        alloc |-> !free_empty)
        else begin
            $error("allocation from an empty free list");
            fail_count++;
        end

endmodule

// ==== sim/rename_tb.sv ====
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ;

    typedef struct packed {
        logic        valid;
        rename_req_t req;
        logic        restore;
        page_idx_t   rpage;
        logic        rel;
        phys_tag_t   rtag;
        logic        exp_stall;
    } row_t;

    logic        clk;
    logic        reset;
    logic        req_valid;
    rename_req_t req;
    logic        restore_valid;
    page_idx_t   restore_page;
    commit_t     commit_release;
    logic        stall;
    logic        rsp_valid;
    rename_rsp_t rsp;

    row_t        rows [$];
    int          errors;
    int          failed_tests;
    int          mark;
    logic        table_ready;
    logic        exp_valid;
    rename_rsp_t exp_rsp;

    // reference model state.
    phys_tag_t ref_map [arch_count];
    phys_tag_t ref_free [$];
    phys_tag_t rel_log [$];
    phys_tag_t ckpt_map [page_count][arch_count];
    phys_tag_t ckpt_free [page_count][$];
    int        ckpt_rel_len [page_count];

    rename_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .restore_valid  (restore_valid),
        .restore_page   (restore_page),
        .commit_release (commit_release),
        .stall          (stall),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp)
    );

    bind rename_top rename_assertions asrt0 (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .stall      (stall),
        .rsp_valid  (rsp_valid),
        .free_empty (free_empty),
        .alloc      (alloc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // helpers

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input int valid, input rv_opcode_e op, input int rd, input int rs1,
                           input int rs2, input int save, input int spage, input int restore,
                           input int rpage, input int rel, input int rtag, input int exp_stall);
        row_t r;
        r.valid         = (valid != 0);
        r.req.opcode    = op;
        r.req.rd        = arch_idx_t'(rd);
        r.req.rs1       = arch_idx_t'(rs1);
        r.req.rs2       = arch_idx_t'(rs2);
        r.req.save      = (save != 0);
        r.req.save_page = page_idx_t'(spage);
        r.restore       = (restore != 0);
        r.rpage         = page_idx_t'(rpage);
        r.rel           = (rel != 0);
        r.rtag          = phys_tag_t'(rtag);
        r.exp_stall     = (exp_stall != 0);
        rows.push_back(r);
    endtask

    // columns are valid, op, rd, rs1, rs2, save, page, restore, page, release, tag, stall.
    task automatic build_table();
        add_row(1, op_op,      1,  2,  3, 0, 0, 0, 0, 0, 0, 0);  // identity mapping.
        add_row(1, op_op,      4,  5,  6, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_jalr,    7,  8,  9, 0, 0, 0, 0, 0, 0, 0);  // rs1 only.
        add_row(1, op_load,   10, 11, 12, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_op_imm, 11, 12, 13, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_lui,    13, 14, 15, 0, 0, 0, 0, 0, 0, 0);  // no sources.
        add_row(1, op_auipc,  14, 15, 16, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_jal,    15, 16, 17, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_store,   5,  1,  4, 0, 0, 0, 0, 0, 0, 0);  // no destination.
        add_row(1, op_branch,  6,  0,  4, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_op,      0,  0,  0, 0, 0, 0, 0, 0, 0, 0);  // x0 everywhere.
        add_row(0, op_op,      9,  9,  9, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_op,     20,  1,  4, 0, 0, 0, 0, 0, 0, 0);  // read after write.
        add_row(1, op_op,      1,  1, 20, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_branch,  0,  1, 20, 1, 3, 0, 0, 0, 0, 0);  // checkpoint to page 3.
        add_row(1, op_op,      1, 20,  1, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_lui,     2,  0,  0, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_op,      3,  1,  2, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_op,      9,  1,  2, 0, 0, 1, 3, 0, 0, 1);
        add_row(1, op_op,      5,  1,  2, 0, 0, 0, 0, 0, 0, 0);
        for (int k = 0; k < 21; k++) begin
            add_row(1, op_op, 8 + k % 8, k % 32, 1, 0, 0, 0, 0, 0, 0, 0);
        end
        add_row(1, op_op,      9,  1,  2, 0, 0, 0, 0, 0, 0, 1);  // free list is empty.
        add_row(1, op_op,      9,  1,  2, 0, 0, 0, 0, 1, 1, 1);
        add_row(1, op_op,      9,  1,  2, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, op_jal,    10,  0,  0, 0, 0, 0, 0, 0, 0, 1);
        add_row(1, op_store,   0,  3,  4, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, op_op,      0,  0,  0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    ////////////////////
    // reference model

    task automatic classify(input rename_req_t r, output logic s1, output logic s2,
                            output logic d);
        s1 = (r.rs1 != '0);
        s2 = (r.rs2 != '0);
        d  = (r.rd != '0);
        case (r.opcode)
            op_jalr, op_load, op_op_imm: s2 = 1'b0;
            op_lui, op_auipc, op_jal: begin
                s1 = 1'b0;
                s2 = 1'b0;
            end
            op_store, op_branch: d = 1'b0;
            default: ;
        endcase
    endtask

    task automatic predict(input row_t r);
        logic u1;
        logic u2;
        logic ud;
        int   p;
        classify(r.req, u1, u2, ud);
        exp_valid = r.valid && !r.exp_stall;
        if (exp_valid) begin
            exp_rsp           = '0;
            exp_rsp.src1_used = u1;
            exp_rsp.src2_used = u2;
            exp_rsp.dst_used  = ud;
            exp_rsp.src1_tag  = u1 ? ref_map[r.req.rs1] : '0;
            exp_rsp.src2_tag  = u2 ? ref_map[r.req.rs2] : '0;
            if (ud) begin
                exp_rsp.dst_tag     = ref_free.pop_front();
                exp_rsp.old_tag     = ref_map[r.req.rd];
                ref_map[r.req.rd]   = exp_rsp.dst_tag;
            end
            if (r.req.save) begin
                ckpt_map[r.req.save_page]     = ref_map;
                ckpt_free[r.req.save_page]    = ref_free;
                ckpt_rel_len[r.req.save_page] = rel_log.size();
            end
        end
        if (r.rel) begin
            ref_free.push_back(r.rtag);
            rel_log.push_back(r.rtag);
        end
        if (r.restore) begin
            p        = int'(r.rpage);
            ref_map  = ckpt_map[p];
            ref_free = ckpt_free[p];
            for (int k = ckpt_rel_len[p]; k < rel_log.size(); k++) begin
                ref_free.push_back(rel_log[k]);   // released after the save, still free.
            end
        end
    endtask

    task automatic check_response(input int idx);
        check_value("rsp_valid", 32'(rsp_valid), 32'(exp_valid));
        if (exp_valid) begin
            check_value("src1_tag", 32'(rsp.src1_tag), 32'(exp_rsp.src1_tag));
            check_value("src1_used", 32'(rsp.src1_used), 32'(exp_rsp.src1_used));
            check_value("src2_tag", 32'(rsp.src2_tag), 32'(exp_rsp.src2_tag));
            check_value("src2_used", 32'(rsp.src2_used), 32'(exp_rsp.src2_used));
            check_value("dst_tag", 32'(rsp.dst_tag), 32'(exp_rsp.dst_tag));
            check_value("old_tag", 32'(rsp.old_tag), 32'(exp_rsp.old_tag));
            check_value("dst_used", 32'(rsp.dst_used), 32'(exp_rsp.dst_used));
        end
        if (errors != mark) begin
            failed_tests++;
        end
        $display("test %0d: %s", idx, (errors == mark) ? "ok" : "mismatch");
    endtask

    ////////////////////
    // main sequence

    initial begin
        reset          = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        restore_valid  = 1'b0;
        restore_page   = '0;
        commit_release = '0;
        errors         = 0;
        failed_tests   = 0;
        mark           = 0;
        exp_valid      = 1'b0;
        exp_rsp        = '0;
        table_ready    = 1'b0;
        for (int i = 0; i < arch_count; i++) begin
            ref_map[i] = phys_tag_t'(i);
        end
        for (int i = 0; i < free_depth; i++) begin
            ref_free.push_back(phys_tag_t'(arch_count + i));
        end
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i <= rows.size(); i++) begin
            if (i > 0) begin
                @(negedge clk);
                check_response(i - 1);
            end
            if (i < rows.size()) begin
                mark                 = errors;
                req_valid            = rows[i].valid;
                req                  = rows[i].req;
                restore_valid        = rows[i].restore;
                restore_page         = rows[i].rpage;
                commit_release.valid = rows[i].rel;
                commit_release.tag   = rows[i].rtag;
                #1;
                check_value("stall", 32'(stall), 32'(rows[i].exp_stall));
                predict(rows[i]);
            end
        end
        $display("%0d tests run, %0d failed, %0d mismatches, %0d assertion failures",
                 rows.size(), failed_tests, errors, dut0.asrt0.fail_count);
        if (errors == 0 && dut0.asrt0.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // four clock periods of slack per table row.
    initial begin
        wait (table_ready);
        #(rows.size() * 4 * 4);
        $display("watchdog: the test table did not finish in %0d ns", rows.size() * 16);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/rename_pkg.sv
logic/rename_ctrl.sv
logic/rat_map_table.sv
logic/free_list.sv
logic/rename_top.sv
sim/rename_assertions.sv
sim/rename_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the rename stage testbench with verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rename_tb -Mdir obj_dir -f flist.f
./obj_dir/Vrename_tb 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without a reported failure"
